// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - rv_core_pkg.sv
  - rv_fetch.sv
  - rv_decode.sv
  - rv_regfile.sv
  - rv_exec.sv
  - rv_core.sv
  - target: test
    files:
      - rv_core_tb.sv

// ==== flist.f ====
+incdir+.
rv_core_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_exec.sv
rv_core.sv
rv_core_tb.sv

// ==== rv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_macros.svh"

module rv_core (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`XLEN-1:0]       insn,
  output logic [`XLEN-1:0]       pc,
  output logic                   halt,
  output logic                   wb_en,
  output logic [`REG_ADDR_W-1:0] wb_rd,
  output logic [`XLEN-1:0]       wb_data,
  output logic                   illegal
);

  logic [`REG_ADDR_W-1:0] rs1;
  logic [`REG_ADDR_W-1:0] rs2;
  rv_core_pkg::alu_op_e   alu_op;
  logic [`XLEN-1:0]       imm;
  logic                   use_imm;
  logic                   use_pc;
  logic                   is_branch;
  logic [2:0]             branch_funct3;
  logic                   halt_req;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;
  logic                   branch_taken;
  logic [`XLEN-1:0]       branch_target;

  rv_fetch fetch_inst (
    .clk           (clk),
    .rst           (rst),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .halt_req      (halt_req),
    .pc            (pc),
    .halt          (halt)
  );

  // retire outputs come straight from decode and execute
  rv_decode decode_inst (
    .insn          (insn),
    .rs1           (rs1),
    .rs2           (rs2),
    .rd            (wb_rd),
    .alu_op        (alu_op),
    .imm           (imm),
    .use_imm       (use_imm),
    .use_pc        (use_pc),
    .wb_req        (wb_en),
    .is_branch     (is_branch),
    .branch_funct3 (branch_funct3),
    .halt_req      (halt_req),
    .illegal       (illegal)
  );

  rv_regfile regfile_inst (
    .clk      (clk),
    .rst      (rst),
    .we       (wb_en),
    .rd       (wb_rd),
    .rd_data  (wb_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_exec exec_inst (
    .pc            (pc),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .imm           (imm),
    .alu_op        (alu_op),
    .use_imm       (use_imm),
    .use_pc        (use_pc),
    .is_branch     (is_branch),
    .branch_funct3 (branch_funct3),
    .wb_data       (wb_data),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

endmodule

`default_nettype wire

// ==== rv_core_macros.svh ====
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// register and datapath width
`define XLEN 32

// architectural integer registers
`define REG_COUNT 32

// index width for rs1, rs2 and rd
`define REG_ADDR_W 5

// major opcode field, insn[6:0]
`define OPCODE_W 7

// byte step between sequential instructions
`define PC_STEP 4

// fetch address out of reset
`define RESET_PC 0

`endif

// ==== rv_core_pkg.sv ====
`default_nettype none

`include "rv_core_macros.svh"

package rv_core_pkg;

  // major opcodes handled by the core
  typedef enum logic [`OPCODE_W-1:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_BRANCH = 7'b1100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // funct3 for op and op-imm
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // alt value selects sub and sra/srai
  localparam logic [6:0] F7_NORMAL = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    logic [6:0]                  funct7;
    logic [`REG_ADDR_W-1:0]      rs2;
    logic [`REG_ADDR_W-1:0]      rs1;
    logic [2:0]                  funct3;
    logic [`REG_ADDR_W-1:0]      rd;
    logic [`OPCODE_W-1:0]        opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]                 imm;
    logic [`REG_ADDR_W-1:0]      rs1;
    logic [2:0]                  funct3;
    logic [`REG_ADDR_W-1:0]      rd;
    logic [`OPCODE_W-1:0]        opcode;
  } i_fmt_t;

  // branch offset bits are scattered across the word
  typedef struct packed {
    logic                        imm_12;
    logic [5:0]                  imm_10_5;
    logic [`REG_ADDR_W-1:0]      rs2;
    logic [`REG_ADDR_W-1:0]      rs1;
    logic [2:0]                  funct3;
    logic [3:0]                  imm_4_1;
    logic                        imm_11;
    logic [`OPCODE_W-1:0]        opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]                 imm_31_12;
    logic [`REG_ADDR_W-1:0]      rd;
    logic [`OPCODE_W-1:0]        opcode;
  } u_fmt_t;

  // one instruction word, four views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    b_fmt_t b;
    u_fmt_t u;
  } insn_u;

endpackage

`default_nettype wire

// ==== rv_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_macros.svh"

module rv_core_tb;

  localparam int          PROG_LEN    = 200;
  localparam int          CYCLE_LIMIT = 2 * PROG_LEN + 50;
  localparam time         HALF_PERIOD = 50;
  localparam time         DRIVE_DELAY = 2;
  localparam logic [31:0] ECALL_WORD  = 32'h0000_0073;

  logic                   clk;
  logic                   rst;
  logic [`XLEN-1:0]       insn;
  logic [`XLEN-1:0]       pc;
  logic                   halt;
  logic                   wb_en;
  logic [`REG_ADDR_W-1:0] wb_rd;
  logic [`XLEN-1:0]       wb_data;
  logic                   illegal;

  logic [31:0] lfsr_state;
  logic [31:0] prog [PROG_LEN];
  int          cycle_count = 0;

  // reference model state and the expected retire of the current word
  logic [31:0] model_regs [`REG_COUNT];
  logic [31:0] model_pc;
  logic        exp_wb_en;
  logic        exp_illegal;
  logic        exp_halt;
  logic [31:0] exp_data;
  logic [31:0] exp_next_pc;

  rv_core rv_core_inst (
    .clk     (clk),
    .rst     (rst),
    .insn    (insn),
    .pc      (pc),
    .halt    (halt),
    .wb_en   (wb_en),
    .wb_rd   (wb_rd),
    .wb_data (wb_data),
    .illegal (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: core did not halt within %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic build_program();
    rv_core_pkg::insn_u w;
    logic [31:0]        cls;
    for (int k = 0; k < PROG_LEN; k++) begin
      w   = take_bits(32);
      cls = take_bits(3) % 5;
      case (cls)
        0: w.u.opcode = rv_core_pkg::OPC_LUI;
        1: w.u.opcode = rv_core_pkg::OPC_AUIPC;
        2: begin
          w.i.opcode = rv_core_pkg::OPC_OP_IMM;
          if (take_bits(4) == 0) begin
            // shift with a funct7 that is neither normal nor alt
            w.r.funct3 = {w.r.funct3[2], 2'b01};
            w.r.funct7 = {w.r.funct7[6:1], 1'b1};
          end else if (w.r.funct3 == rv_core_pkg::F3_SLL) begin
            w.r.funct7 = rv_core_pkg::F7_NORMAL;
          end else if (w.r.funct3 == rv_core_pkg::F3_SRL_SRA) begin
            w.r.funct7 = take_bits(1) ? rv_core_pkg::F7_ALT : rv_core_pkg::F7_NORMAL;
          end
        end
        3: begin
          w.r.opcode = rv_core_pkg::OPC_OP;
          w.r.funct7 = rv_core_pkg::F7_NORMAL;
          if ((w.r.funct3 == rv_core_pkg::F3_ADD_SUB ||
               w.r.funct3 == rv_core_pkg::F3_SRL_SRA) && take_bits(1)) begin
            w.r.funct7 = rv_core_pkg::F7_ALT;
          end
        end
        default: begin
          w.b.opcode = rv_core_pkg::OPC_BRANCH;
          case (take_bits(3) % 6)
            0:       w.b.funct3 = rv_core_pkg::F3_BEQ;
            1:       w.b.funct3 = rv_core_pkg::F3_BNE;
            2:       w.b.funct3 = rv_core_pkg::F3_BLT;
            3:       w.b.funct3 = rv_core_pkg::F3_BGE;
            4:       w.b.funct3 = rv_core_pkg::F3_BLTU;
            default: w.b.funct3 = rv_core_pkg::F3_BGEU;
          endcase
          // forward by 8 or 12 bytes
          w.b.imm_12   = 1'b0;
          w.b.imm_11   = 1'b0;
          w.b.imm_10_5 = 6'd0;
          w.b.imm_4_1  = take_bits(1) ? 4'd6 : 4'd4;
        end
      endcase
      prog[k] = w;
    end
  endtask

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if ((addr >> 2) < PROG_LEN) begin
      return prog[addr >> 2];
    end
    return ECALL_WORD;
  endfunction

  function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'd0, $signed(a) < $signed(b)};
      3'b011:  return {31'd0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic model_execute(input logic [31:0] word);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic        taken;
    f3    = word[14:12];
    f7    = word[31:25];
    a     = model_regs[word[19:15]];
    b     = model_regs[word[24:20]];
    imm_i = {{20{word[31]}}, word[31:20]};
    imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
    exp_wb_en   = 1'b0;
    exp_illegal = 1'b0;
    exp_halt    = 1'b0;
    exp_data    = '0;
    exp_next_pc = model_pc + 32'd4;
    taken       = 1'b0;
    case (word[6:0])
      rv_core_pkg::OPC_LUI: begin
        exp_wb_en = 1'b1;
        exp_data  = {word[31:12], 12'd0};
      end
      rv_core_pkg::OPC_AUIPC: begin
        exp_wb_en = 1'b1;
        exp_data  = model_pc + {word[31:12], 12'd0};
      end
      rv_core_pkg::OPC_OP_IMM: begin
        exp_illegal = (f3 == 3'b001 && f7 != 7'h00) ||
                      (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);
        exp_data    = alu_result(f3, f3 == 3'b101 && f7 == 7'h20, a, imm_i);
      end
      rv_core_pkg::OPC_OP: begin
        exp_illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
        exp_data    = alu_result(f3, f7 == 7'h20, a, b);
      end
      rv_core_pkg::OPC_BRANCH: begin
        case (f3)
          3'b000:  taken = a == b;
          3'b001:  taken = a != b;
          3'b100:  taken = $signed(a) < $signed(b);
          3'b101:  taken = $signed(a) >= $signed(b);
          3'b110:  taken = a < b;
          3'b111:  taken = a >= b;
          default: exp_illegal = 1'b1;
        endcase
        if (taken) begin
          exp_next_pc = model_pc + imm_b;
        end
      end
      rv_core_pkg::OPC_SYSTEM: begin
        exp_halt    = word[31:7] == '0;
        exp_illegal = !exp_halt;
        if (exp_halt) begin
          exp_next_pc = model_pc;
        end
      end
      default: exp_illegal = 1'b1;
    endcase
    if (word[6:0] == rv_core_pkg::OPC_OP_IMM || word[6:0] == rv_core_pkg::OPC_OP) begin
      exp_wb_en = !exp_illegal;
    end
  endtask

  initial begin
    rst        = 1'b1;
    insn       = ECALL_WORD;
    lfsr_state = 32'h0da7_48fd;
    build_program();
    for (int i = 0; i < `REG_COUNT; i++) begin
      model_regs[i] = '0;
    end
    repeat (5) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    check_value("pc", pc, `XLEN'(`RESET_PC));
    check_value("halt", halt, 1'b0);
    model_pc = `XLEN'(`RESET_PC);
    exp_halt = 1'b0;
    while (!exp_halt) begin
      check_value("pc", pc, model_pc);
      check_value("halt", halt, 1'b0);
      insn = fetch_word(pc);
      model_execute(insn);
      @(negedge clk);
      check_value("wb_en", wb_en, exp_wb_en);
      check_value("illegal", illegal, exp_illegal);
      if (exp_wb_en) begin
        check_value("wb_rd", wb_rd, insn[11:7]);
        check_value("wb_data", wb_data, exp_data);
        // x0 stays zero in the model
        if (insn[11:7] != 5'd0) begin
          model_regs[insn[11:7]] = exp_data;
        end
      end
      model_pc = exp_next_pc;
      @(posedge clk);
      #DRIVE_DELAY;
    end
    // parked on the ecall
    repeat (10) begin
      check_value("halt", halt, 1'b1);
      check_value("pc", pc, model_pc);
      insn = fetch_word(pc);
      @(posedge clk);
      #DRIVE_DELAY;
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_macros.svh"

module rv_decode (
  input  logic [`XLEN-1:0]       insn,
  output logic [`REG_ADDR_W-1:0] rs1,
  output logic [`REG_ADDR_W-1:0] rs2,
  output logic [`REG_ADDR_W-1:0] rd,
  output rv_core_pkg::alu_op_e   alu_op,
  output logic [`XLEN-1:0]       imm,
  output logic                   use_imm,
  output logic                   use_pc,
  output logic                   wb_req,
  output logic                   is_branch,
  output logic [2:0]             branch_funct3,
  output logic                   halt_req,
  output logic                   illegal
);

  rv_core_pkg::insn_u word;
  logic [`XLEN-1:0]   imm_i;
  logic [`XLEN-1:0]   imm_b;
  logic [`XLEN-1:0]   imm_u;
  logic               is_op;
  logic               f7_normal;
  logic               f7_alt;

  assign word = insn;

  // register fields sit in the same place for every format
  assign rs1           = word.r.rs1;
  assign rs2           = word.r.rs2;
  assign rd            = word.r.rd;
  assign branch_funct3 = word.r.funct3;

  assign imm_i = {{(`XLEN-12){word.i.imm[11]}}, word.i.imm};
  assign imm_b = {{(`XLEN-12){word.b.imm_12}}, word.b.imm_11, word.b.imm_10_5,
                  word.b.imm_4_1, 1'b0};
  assign imm_u = {word.u.imm_31_12, 12'b0};

  assign is_op     = word.r.opcode == rv_core_pkg::OPC_OP;
  assign f7_normal = word.r.funct7 == rv_core_pkg::F7_NORMAL;
  assign f7_alt    = word.r.funct7 == rv_core_pkg::F7_ALT;

  always_comb begin
    alu_op    = rv_core_pkg::ALU_ADD;
    imm       = '0;
    use_imm   = 1'b0;
    use_pc    = 1'b0;
    wb_req    = 1'b0;
    is_branch = 1'b0;
    halt_req  = 1'b0;
    illegal   = 1'b0;
    case (word.r.opcode)
      rv_core_pkg::OPC_LUI: begin
        alu_op  = rv_core_pkg::ALU_PASS_B;
        imm     = imm_u;
        use_imm = 1'b1;
        wb_req  = 1'b1;
      end
      rv_core_pkg::OPC_AUIPC: begin
        imm     = imm_u;
        use_imm = 1'b1;
        use_pc  = 1'b1;
        wb_req  = 1'b1;
      end
      rv_core_pkg::OPC_OP_IMM, rv_core_pkg::OPC_OP: begin
        imm     = imm_i;
        use_imm = !is_op;
        wb_req  = 1'b1;
        // only register ops carry funct7 outside of shifts
        case (word.r.funct3)
          rv_core_pkg::F3_ADD_SUB: begin
            if (is_op && f7_alt) begin
              alu_op = rv_core_pkg::ALU_SUB;
            end else begin
              illegal = is_op && !f7_normal;
            end
          end
          rv_core_pkg::F3_SLL: begin
            alu_op  = rv_core_pkg::ALU_SLL;
            illegal = !f7_normal;
          end
          rv_core_pkg::F3_SLT: begin
            alu_op  = rv_core_pkg::ALU_SLT;
            illegal = is_op && !f7_normal;
          end
          rv_core_pkg::F3_SLTU: begin
            alu_op  = rv_core_pkg::ALU_SLTU;
            illegal = is_op && !f7_normal;
          end
          rv_core_pkg::F3_XOR: begin
            alu_op  = rv_core_pkg::ALU_XOR;
            illegal = is_op && !f7_normal;
          end
          rv_core_pkg::F3_SRL_SRA: begin
            alu_op  = f7_alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            illegal = !f7_normal && !f7_alt;
          end
          rv_core_pkg::F3_OR: begin
            alu_op  = rv_core_pkg::ALU_OR;
            illegal = is_op && !f7_normal;
          end
          default: begin
            alu_op  = rv_core_pkg::ALU_AND;
            illegal = is_op && !f7_normal;
          end
        endcase
      end
      rv_core_pkg::OPC_BRANCH: begin
        imm = imm_b;
        // funct3 010 and 011 are not branches
        illegal   = word.b.funct3[2:1] == 2'b01;
        is_branch = !illegal;
      end
      rv_core_pkg::OPC_SYSTEM: begin
        // ecall is the only supported system word
        halt_req = insn[`XLEN-1:`OPCODE_W] == '0;
        illegal  = !halt_req;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
    // illegal words retire as no-ops
    wb_req = wb_req && !illegal;
  end

endmodule

`default_nettype wire

// ==== rv_exec.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_macros.svh"

module rv_exec (
  input  logic [`XLEN-1:0]     pc,
  input  logic [`XLEN-1:0]     rs1_data,
  input  logic [`XLEN-1:0]     rs2_data,
  input  logic [`XLEN-1:0]     imm,
  input  rv_core_pkg::alu_op_e alu_op,
  input  logic                 use_imm,
  input  logic                 use_pc,
  input  logic                 is_branch,
  input  logic [2:0]           branch_funct3,
  output logic [`XLEN-1:0]     wb_data,
  output logic                 branch_taken,
  output logic [`XLEN-1:0]     branch_target
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [4:0]       shamt;
  logic             eq;
  logic             lt;
  logic             ltu;
  logic             cond;

  assign op_a  = use_pc ? pc : rs1_data;
  assign op_b  = use_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  // comparators are shared by slt/sltu and the branches
  assign eq  = op_a == op_b;
  assign lt  = $signed(op_a) < $signed(op_b);
  assign ltu = op_a < op_b;

  always_comb begin
    case (alu_op)
      rv_core_pkg::ALU_ADD:    wb_data = op_a + op_b;
      rv_core_pkg::ALU_SUB:    wb_data = op_a - op_b;
      rv_core_pkg::ALU_SLL:    wb_data = op_a << shamt;
      rv_core_pkg::ALU_SLT:    wb_data = {{(`XLEN-1){1'b0}}, lt};
      rv_core_pkg::ALU_SLTU:   wb_data = {{(`XLEN-1){1'b0}}, ltu};
      rv_core_pkg::ALU_XOR:    wb_data = op_a ^ op_b;
      rv_core_pkg::ALU_SRL:    wb_data = op_a >> shamt;
      rv_core_pkg::ALU_SRA:    wb_data = $unsigned($signed(op_a) >>> shamt);
      rv_core_pkg::ALU_OR:     wb_data = op_a | op_b;
      rv_core_pkg::ALU_AND:    wb_data = op_a & op_b;
      rv_core_pkg::ALU_PASS_B: wb_data = op_b;
      default:                 wb_data = '0;
    endcase
  end

  // decode clears use_pc and use_imm so branches compare rs1 with rs2
  always_comb begin
    case (branch_funct3)
      rv_core_pkg::F3_BEQ:  cond = eq;
      rv_core_pkg::F3_BNE:  cond = !eq;
      rv_core_pkg::F3_BLT:  cond = lt;
      rv_core_pkg::F3_BGE:  cond = !lt;
      rv_core_pkg::F3_BLTU: cond = ltu;
      rv_core_pkg::F3_BGEU: cond = !ltu;
      default:              cond = 1'b0;
    endcase
  end

  assign branch_taken  = is_branch && cond;
  assign branch_target = pc + imm;

endmodule

`default_nettype wire

// ==== rv_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_macros.svh"

module rv_fetch (
  input  logic             clk,
  input  logic             rst,
  input  logic             branch_taken,
  input  logic [`XLEN-1:0] branch_target,
  input  logic             halt_req,
  output logic [`XLEN-1:0] pc,
  output logic             halt
);

  logic [`XLEN-1:0] pc_next;

  // ecall parks the pc on itself
  always_comb begin
    if (halt_req) begin
      pc_next = pc;
    end else if (branch_taken) begin
      pc_next = branch_target;
    end else begin
      pc_next = pc + `XLEN'(`PC_STEP);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= `XLEN'(`RESET_PC);
      halt <= 1'b0;
    end else begin
      pc <= pc_next;
      // sticky until reset
      if (halt_req) begin
        halt <= 1'b1;
      end
    end
  end

  // exec forms branch targets without an alignment check
  pc_word_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

  // once halted the pc stays parked on the ecall
  halt_parks_pc: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(pc))
    else $error("pc moved after halt: %h", pc);

endmodule

`default_nettype wire

// ==== rv_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_macros.svh"

module rv_regfile (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   we,
  input  logic [`REG_ADDR_W-1:0] rd,
  input  logic [`XLEN-1:0]       rd_data,
  input  logic [`REG_ADDR_W-1:0] rs1,
  input  logic [`REG_ADDR_W-1:0] rs2,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // x0 is hardwired
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire
